/* run_sim.sh */
#!/bin/sh
# Build the video fetch core with its testbench and run the simulation.
# A $fatal in the testbench gives a failing exit status.
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module vic_fetch_tb \
  -f vic_fetch.f --Mdir obj_dir -o vic_fetch_sim &&
./obj_dir/vic_fetch_sim &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

/* source/vic_fetch_pkg.sv */
// Fetch sequencer types

package vic_fetch_pkg;

  // ========================================================================
  // Sequencer encodings
  // ========================================================================

  // Which kind of access burst is running, if any
  typedef enum logic [1:0] {
    st_idle,
    st_c_access,
    st_g_access
  } fetch_state_e;

  // Phase inside one four clock memory access
  typedef enum logic [1:0] {
    // Low address byte out, ras_n low
    ph_row,
    // High address bits out, cas_n low as well
    ph_col,
    // Memory data is sampled at the end of this clock
    ph_data,
    // Both strobes back high
    ph_rel
  } acc_phase_e;

  // One character cell as read by a c-access
  // The colour nibble sits above the code, matching the 12-bit data bus
  typedef struct packed {
    vic_reg_pkg::color_t color;
    logic [7:0]          code;
  } char_entry_t;

endpackage

/* source/vic_fetch_seq.sv */
// Raster counters and memory fetch sequencer
`include "vic_macros.svh"

module vic_fetch_seq (
  input  logic         clk,
  input  logic         rst,
  vic_cfg_if.cfg_fetch cfg,
  vic_fetch_if.src     fetch,
  output logic [7:0]   mem_adr,
  input  logic [11:0]  mem_dat,
  output logic         ras_n,
  output logic         cas_n,
  output logic         ba
);
  import vic_fetch_pkg::*;

  localparam int CYC_W = $clog2(`VIC_LINE_CYCLES);
  localparam int COL_W = $clog2(`VIC_COLS);

  // Line cycle landmarks, the bursts are launched one clock early so that
  // the registered state shows the row phase on the start cycle itself
  localparam logic [CYC_W-1:0] CYC_LAST = CYC_W'(`VIC_LINE_CYCLES - 1);
  localparam logic [CYC_W-1:0] CYC_BA   = CYC_W'(`VIC_BA_CYCLE);
  localparam logic [CYC_W-1:0] C_LAUNCH = CYC_W'(`VIC_C_START - 1);
  localparam logic [CYC_W-1:0] G_LAUNCH = CYC_W'(`VIC_G_START - 1);
  localparam logic [CYC_W-1:0] C_END    =
    CYC_W'(`VIC_C_START + `VIC_COLS * `VIC_ACC_CYCLES);
  localparam logic [7:0]       RAS_LAST  = 8'(`VIC_LINES - 1);
  localparam logic [7:0]       WIN_FIRST = 8'(`VIC_DISP_FIRST);
  localparam logic [7:0]       WIN_LAST  = 8'(`VIC_DISP_LAST);
  localparam logic [COL_W-1:0] COL_LAST  = COL_W'(`VIC_COLS - 1);

  logic [CYC_W-1:0] cycle;
  logic [7:0]       raster;
  // Video counter at the start of the current text row
  logic [9:0]       vc_base;
  logic [2:0]       rc;
  logic             display_state;
  fetch_state_e     state;
  acc_phase_e       phase;
  logic [COL_W-1:0] col;
  // Character codes of the current text row, reused by every g-access
  logic [7:0]       code_buf [`VIC_COLS];
  logic [13:0]      acc_addr;
  logic             in_window;
  logic             bad_line;
  logic             disp_line;
  logic             line_end;
  logic             frame_end;

  // ========================================================================
  // Raster position and display state
  // ========================================================================

  assign line_end  = (cycle == CYC_LAST);
  assign frame_end = line_end && (raster == RAS_LAST);
  assign in_window = (raster >= WIN_FIRST) && (raster <= WIN_LAST);
  assign bad_line  = in_window && cfg.den && (raster[2:0] == cfg.yscroll);
  // A bad line counts as a display line even before display_state is set
  assign disp_line = in_window && (display_state || bad_line);

  always_ff @(posedge clk) begin
    if (rst) begin
      cycle         <= '0;
      raster        <= '0;
      vc_base       <= '0;
      rc            <= '0;
      display_state <= 1'b0;
    end else begin
      cycle <= line_end ? '0 : cycle + 1'b1;
      if (line_end) begin
        raster <= (raster == RAS_LAST) ? '0 : raster + 1'b1;
      end
      // Display state lives until the frame wraps
      if (frame_end) begin
        display_state <= 1'b0;
      end else if (bad_line) begin
        display_state <= 1'b1;
      end
      // Each bad line moves the text row on by one row of characters
      if (frame_end) begin
        vc_base <= '0;
      end else if (bad_line && line_end) begin
        vc_base <= vc_base + 10'(`VIC_COLS);
      end
      // Row counter restarts on a bad line and wraps at 7 by width
      if (cycle == '0) begin
        if (bad_line) begin
          rc <= '0;
        end else if (disp_line) begin
          rc <= rc + 1'b1;
        end
      end
    end
  end

  assign cfg.raster = raster;

  // ========================================================================
  // Access sequencer
  // ========================================================================

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
      phase <= ph_row;
      col   <= '0;
    end else begin
      case (state)
        st_idle: begin
          phase <= ph_row;
          col   <= '0;
          if (cycle == C_LAUNCH && bad_line) begin
            state <= st_c_access;
          end else if (cycle == G_LAUNCH && disp_line) begin
            state <= st_g_access;
          end
        end
        default: begin
          case (phase)
            ph_row:  phase <= ph_col;
            ph_col:  phase <= ph_data;
            ph_data: phase <= ph_rel;
            default: begin
              // End of one access, move to the next column or stop
              phase <= ph_row;
              if (col == COL_LAST) begin
                state <= st_idle;
              end else begin
                col <= col + 1'b1;
              end
            end
          endcase
        end
      endcase
    end
  end

  // c-access reads the video matrix, g-access reads the glyph row
  assign acc_addr = (state == st_c_access) ?
                    {cfg.vm_base, vc_base + 10'(col)} :
                    {cfg.cb_base, code_buf[col], rc};

  // Multiplexed address, low byte first and then the top six bits
  always_comb begin
    if (state == st_idle) begin
      mem_adr = 8'h00;
    end else if (phase == ph_row) begin
      mem_adr = acc_addr[7:0];
    end else begin
      mem_adr = {2'b00, acc_addr[13:8]};
    end
  end

  assign ras_n = !((state != st_idle) && (phase != ph_rel));
  assign cas_n = !((state != st_idle) && ((phase == ph_col) || (phase == ph_data)));

  // ba warns the host from its cycle until the last c-access is done
  assign ba = !(bad_line && (cycle >= CYC_BA) && (cycle < C_END));

  // ========================================================================
  // Captured data and result strobes
  // ========================================================================

  always_ff @(posedge clk) begin
    if (rst) begin
      fetch.c_strobe <= 1'b0;
      fetch.g_strobe <= 1'b0;
    end else begin
      fetch.c_strobe <= (state == st_c_access) && (phase == ph_data);
      fetch.g_strobe <= (state == st_g_access) && (phase == ph_data);
    end
  end

  always_ff @(posedge clk) begin
    if (phase == ph_data) begin
      fetch.col <= col;
      if (state == st_c_access) begin
        code_buf[col] <= mem_dat[7:0];
        fetch.c_entry <= mem_dat;
      end
      fetch.g_pattern <= mem_dat[7:0];
    end
  end

  assign fetch.line_start = (cycle == '0) && disp_line;

endmodule

/* source/vic_fetch_top.sv */
// Video fetch core top level

module vic_fetch_top (
  input  logic        clk,
  input  logic        rst,
  // Host register bus
  input  logic        cs_n,
  input  logic        rw,
  input  logic [5:0]  reg_adr,
  input  logic [7:0]  reg_din,
  output logic [7:0]  reg_dout,
  // Multiplexed DRAM bus
  output logic [7:0]  mem_adr,
  input  logic [11:0] mem_dat,
  output logic        ras_n,
  output logic        cas_n,
  output logic        ba,
  // Two pixels per clock
  output logic [7:0]  pix_color,
  output logic        pix_valid
);

  vic_cfg_if   u_cfg_if ();
  vic_fetch_if u_fetch_if ();

  // Decode stage holds the registers
  vic_reg_decode u_reg_decode (
    .clk      (clk),
    .rst      (rst),
    .cs_n     (cs_n),
    .rw       (rw),
    .reg_adr  (reg_adr),
    .reg_din  (reg_din),
    .reg_dout (reg_dout),
    .cfg      (u_cfg_if.cfg_src)
  );

  // Execute stage runs the raster and the memory accesses
  vic_fetch_seq u_fetch_seq (
    .clk     (clk),
    .rst     (rst),
    .cfg     (u_cfg_if.cfg_fetch),
    .fetch   (u_fetch_if.src),
    .mem_adr (mem_adr),
    .mem_dat (mem_dat),
    .ras_n   (ras_n),
    .cas_n   (cas_n),
    .ba      (ba)
  );

  // Result stage turns patterns into pixels
  vic_pixel_out u_pixel_out (
    .clk       (clk),
    .rst       (rst),
    .cfg       (u_cfg_if.cfg_pix),
    .fetch     (u_fetch_if.sink),
    .pix_color (pix_color),
    .pix_valid (pix_valid)
  );

endmodule

/* source/vic_if.sv */
// Configuration and fetch result interfaces
`include "vic_macros.svh"

// Register state seen by the fetch and pixel blocks
interface vic_cfg_if;
  import vic_reg_pkg::*;

  logic       den;
  yscroll_t   yscroll;
  vm_base_t   vm_base;
  cb_base_t   cb_base;
  color_t     bg_color;
  // Raster line coming back from the sequencer for readback
  logic [7:0] raster;

  modport cfg_src (output den, yscroll, vm_base, cb_base, bg_color, input raster);

  modport cfg_fetch (input den, yscroll, vm_base, cb_base, output raster);

  modport cfg_pix (input bg_color);
endinterface

// Fetch results passed from the sequencer to the pixel stage
interface vic_fetch_if;
  import vic_fetch_pkg::*;

  // Character entry from a c-access, one clock wide
  logic                             c_strobe;
  char_entry_t                      c_entry;
  // Glyph pattern from a g-access, one clock wide
  logic                             g_strobe;
  logic [7:0]                       g_pattern;
  // Column of whichever strobe is high
  logic [$clog2(`VIC_COLS)-1:0]     col;
  // First clock of a display-state line inside the window
  logic                             line_start;

  modport src (output c_strobe, c_entry, g_strobe, g_pattern, col, line_start);

  modport sink (input c_strobe, c_entry, g_strobe, g_pattern, col, line_start);
endinterface

/* source/vic_macros.svh */
// Video fetch geometry
`ifndef VIC_MACROS_SVH
`define VIC_MACROS_SVH

// ==========================================================================
// Raster geometry
// ==========================================================================

// Characters fetched per text row
`define VIC_COLS 8
// Clocks in one raster line and lines in one frame
`define VIC_LINE_CYCLES 80
`define VIC_LINES 24
// First and last line of the display window
`define VIC_DISP_FIRST 4
`define VIC_DISP_LAST 19

// ==========================================================================
// Fetch timing inside a line
// ==========================================================================

// Line cycle where ba drops on a bad line
`define VIC_BA_CYCLE 4
// First clock of the c-access and g-access bursts
`define VIC_C_START 8
`define VIC_G_START 44
// Clocks per memory access, one per phase
`define VIC_ACC_CYCLES 4

`endif

/* source/vic_pixel_out.sv */
// Pattern shifter and pixel colour
`include "vic_macros.svh"

module vic_pixel_out (
  input  logic       clk,
  input  logic       rst,
  vic_cfg_if.cfg_pix cfg,
  vic_fetch_if.sink  fetch,
  output logic [7:0] pix_color,
  output logic       pix_valid
);
  import vic_reg_pkg::*;
  import vic_fetch_pkg::*;

  // Character entries of the current text row
  char_entry_t line_buf [`VIC_COLS];

  // Glyph bits still to go out, two per clock from the top
  logic [7:0] shifter;
  // Foreground colour of the character being shown
  color_t     fg_color;
  // Pixel pair number within the current glyph
  logic [1:0] pair_cnt;
  logic       active;

  // ========================================================================
  // Character line buffer
  // ========================================================================

  // Written on bad lines only, later lines of the row reuse the contents
  always_ff @(posedge clk) begin
    if (fetch.c_strobe) begin
      line_buf[fetch.col] <= fetch.c_entry;
    end
  end

  // ========================================================================
  // Shifter
  // ========================================================================

  // Payload side, loaded on every pattern and shifted while active
  always_ff @(posedge clk) begin
    if (fetch.g_strobe) begin
      shifter  <= fetch.g_pattern;
      fg_color <= line_buf[fetch.col].color;
    end else if (active) begin
      shifter <= {shifter[5:0], 2'b00};
    end
  end

  // The next pattern arrives on the clock of the last pair, so the
  // stream runs without a gap across the columns of a line
  always_ff @(posedge clk) begin
    if (rst) begin
      active   <= 1'b0;
      pair_cnt <= '0;
    end else if (fetch.g_strobe) begin
      active   <= 1'b1;
      pair_cnt <= '0;
    end else if (fetch.line_start) begin
      // Nothing from the previous line may leak into a new one
      active   <= 1'b0;
      pair_cnt <= '0;
    end else if (active) begin
      pair_cnt <= pair_cnt + 1'b1;
      if (pair_cnt == 2'd3) begin
        active <= 1'b0;
      end
    end
  end

  // ========================================================================
  // Colour selection
  // ========================================================================

  // First pixel of the pair in the high nibble
  // A set bit shows the character colour and a clear bit the background
  assign pix_color = {shifter[7] ? fg_color : cfg.bg_color,
                      shifter[6] ? fg_color : cfg.bg_color};
  assign pix_valid = active;

endmodule

/* source/vic_reg_decode.sv */
// Host register decode

module vic_reg_decode (
  input  logic       clk,
  input  logic       rst,
  input  logic       cs_n,
  input  logic       rw,
  input  logic [5:0] reg_adr,
  input  logic [7:0] reg_din,
  output logic [7:0] reg_dout,
  vic_cfg_if.cfg_src cfg
);
  import vic_reg_pkg::*;

  // Stored register fields, only the bits that have a meaning are kept
  logic       den_q;
  yscroll_t   yscroll_q;
  vm_base_t   vm_base_q;
  cb_base_t   cb_base_q;
  color_t     bg_color_q;
  logic [7:0] rd_data;

  // ========================================================================
  // Register writes
  // ========================================================================

  // A write lands on any clock where both cs_n and rw are low
  always_ff @(posedge clk) begin
    if (rst) begin
      den_q      <= 1'b0;
      yscroll_q  <= '0;
      vm_base_q  <= '0;
      cb_base_q  <= '0;
      bg_color_q <= '0;
    end else if (!cs_n && !rw) begin
      case (reg_addr_e'(reg_adr))
        reg_ctrl: begin
          den_q     <= reg_din[4];
          yscroll_q <= reg_din[2:0];
        end
        reg_memptr: begin
          vm_base_q <= reg_din[7:4];
          cb_base_q <= reg_din[3:1];
        end
        reg_bgcolor: bg_color_q <= reg_din[3:0];
        // The raster register and unmapped numbers ignore writes
        default: ;
      endcase
    end
  end

  // ========================================================================
  // Readback
  // ========================================================================

  // Unused bit positions read as zero
  always_comb begin
    case (reg_addr_e'(reg_adr))
      reg_ctrl:    rd_data = {3'b000, den_q, 1'b0, yscroll_q};
      reg_raster:  rd_data = cfg.raster;
      reg_memptr:  rd_data = {vm_base_q, cb_base_q, 1'b0};
      reg_bgcolor: rd_data = {4'h0, bg_color_q};
      default:     rd_data = 8'hff;
    endcase
  end

  // Read data shows up one clock after the read and holds until the next one
  always_ff @(posedge clk) begin
    if (rst) begin
      reg_dout <= 8'h00;
    end else if (!cs_n && rw) begin
      reg_dout <= rd_data;
    end
  end

  // Fields out to the fetch and pixel blocks
  assign cfg.den      = den_q;
  assign cfg.yscroll  = yscroll_q;
  assign cfg.vm_base  = vm_base_q;
  assign cfg.cb_base  = cb_base_q;
  assign cfg.bg_color = bg_color_q;

endmodule

/* source/vic_reg_pkg.sv */
// Host register map types

package vic_reg_pkg;

  // ========================================================================
  // Register numbers on the host bus
  // ========================================================================

  // Only four registers are mapped and every other number reads as all ones
  typedef enum logic [5:0] {
    // Control with den in bit 4 and yscroll in bits 2:0
    reg_ctrl    = 6'd17,
    // Current raster line, read only
    reg_raster  = 6'd18,
    // Video matrix base in bits 7:4 and character base in bits 3:1
    reg_memptr  = 6'd24,
    // Background colour in bits 3:0
    reg_bgcolor = 6'd33
  } reg_addr_e;

  // ========================================================================
  // Register fields
  // ========================================================================

  // One colour nibble, as in colour RAM
  typedef logic [3:0] color_t;

  // Video matrix base, placed on DRAM address bits 13:10
  typedef logic [3:0] vm_base_t;

  // Character generator base, placed on DRAM address bits 13:11
  typedef logic [2:0] cb_base_t;

  // Vertical scroll, compared against raster bits 2:0 to find bad lines
  typedef logic [2:0] yscroll_t;

endpackage

/* tb/vic_fetch_tb.sv */
// Video fetch core testbench
`include "vic_macros.svh"

module vic_fetch_tb;

  // ==========================================================================
  // Constants and register table
  // ==========================================================================

  localparam int FRAME_CYCLES = `VIC_LINE_CYCLES * `VIC_LINES;
  localparam int RAM_WORDS = 16384;
  localparam logic [31:0] LCG_SEED = 32'hfb48;
  localparam logic [5:0] REG_CTRL = 6'd17;
  localparam logic [5:0] REG_RASTER = 6'd18;
  localparam logic [5:0] REG_MEMPTR = 6'd24;
  localparam logic [5:0] REG_BGCOLOR = 6'd33;

  // Each entry is op, register number, write data or idle count, expected read
  localparam logic [7:0] OP_WR = 8'h00;
  localparam logic [7:0] OP_RD = 8'h01;
  localparam logic [7:0] OP_RAS = 8'h02;
  localparam logic [7:0] OP_IDLE = 8'h03;
  localparam int TABLE_LEN = 18;
  localparam logic [31:0] REG_TABLE [TABLE_LEN] = '{
    {OP_RAS, 8'd18, 8'h00, 8'h00}, {OP_IDLE, 8'd0, 8'd170, 8'h00},
    {OP_RAS, 8'd18, 8'h00, 8'h00}, {OP_WR, 8'd24, 8'hff, 8'h00},
    {OP_RD, 8'd24, 8'h00, 8'hfe}, {OP_WR, 8'd33, 8'ha5, 8'h00},
    {OP_RD, 8'd33, 8'h00, 8'h05}, {OP_WR, 8'd17, 8'hef, 8'h00},
    {OP_RD, 8'd17, 8'h00, 8'h07}, {OP_WR, 8'd17, 8'h00, 8'h00},
    {OP_RD, 8'd17, 8'h00, 8'h00}, {OP_RD, 8'd0, 8'h00, 8'hff},
    {OP_RD, 8'd63, 8'h00, 8'hff}, {OP_RD, 8'd16, 8'h00, 8'hff},
    {OP_WR, 8'd18, 8'h55, 8'h00}, {OP_RAS, 8'd18, 8'h00, 8'h00},
    {OP_IDLE, 8'd0, 8'd200, 8'h00}, {OP_RAS, 8'd18, 8'h00, 8'h00}
  };
  // Three frames plus the longest the table can take (258 clocks an entry) plus reset
  localparam int TIMEOUT_CYCLES = 3 * FRAME_CYCLES + TABLE_LEN * 258 + 16;

  logic        clk;
  logic        rst;
  logic        cs_n;
  logic        rw;
  logic [5:0]  reg_adr;
  logic [7:0]  reg_din;
  logic [7:0]  reg_dout;
  logic [7:0]  mem_adr;
  logic [11:0] mem_dat;
  logic        ras_n;
  logic        cas_n;
  logic        ba;
  logic [7:0]  pix_color;
  logic        pix_valid;

  // Clocks since reset release
  // Modulo one frame this is the DUT frame position
  int unsigned edge_cnt;
  int unsigned run_cycles = 0;
  logic [11:0] vram_ref [RAM_WORDS];
  // Expected accesses and pixel pairs in the order the DUT must produce them
  logic [13:0] exp_addr [$];
  int unsigned exp_pos [$];
  logic        exp_is_c [$];
  logic [7:0]  exp_pix [$];
  // Monitor state
  logic        ras_prev;
  logic        cas_prev;
  int unsigned ba_low_run;
  logic [13:0] cur_addr;
  int unsigned cur_pos;
  logic        cur_is_c;

  vic_fetch_top u_dut (
    .clk(clk), .rst(rst), .cs_n(cs_n), .rw(rw), .reg_adr(reg_adr),
    .reg_din(reg_din), .reg_dout(reg_dout), .mem_adr(mem_adr), .mem_dat(mem_dat),
    .ras_n(ras_n), .cas_n(cas_n), .ba(ba), .pix_color(pix_color), .pix_valid(pix_valid)
  );

  vic_mem_model u_mem (
    .clk(clk), .rst(rst), .mem_adr(mem_adr), .ras_n(ras_n), .cas_n(cas_n),
    .mem_dat(mem_dat)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    if (rst) begin
      edge_cnt <= 0;
    end else begin
      edge_cnt <= edge_cnt + 1;
    end
  end

  always @(posedge clk) begin
    run_cycles <= run_cycles + 1;
    if (run_cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the test sequence did not finish", run_cycles);
      stop_run();
    end
  end

  // ==========================================================================
  // Helpers
  // ==========================================================================

  task automatic stop_run();
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t: %s, got %0h, expected %0h", $time, what, actual,
               expected);
      stop_run();
    end
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Every address takes the next value of one LCG stream
  task automatic fill_video_ram();
    logic [31:0] state;
    state = LCG_SEED;
    for (int a = 0; a < RAM_WORDS; a++) begin
      state = lcg_next(state);
      vram_ref[a] = state[27:16];
      u_mem.ram[a] = state[27:16];
    end
  endtask

  task automatic bus_write(input logic [5:0] adr, input logic [7:0] data);
    @(posedge clk);
    #1;
    cs_n = 1'b0;
    rw = 1'b0;
    reg_adr = adr;
    reg_din = data;
    @(posedge clk);
    #1;
    cs_n = 1'b1;
    rw = 1'b1;
  endtask

  // Returns the read data and the frame position of the read clock
  task automatic bus_read(input logic [5:0] adr, output logic [7:0] data,
                          output int unsigned pos);
    @(posedge clk);
    #1;
    cs_n = 1'b0;
    rw = 1'b1;
    reg_adr = adr;
    pos = edge_cnt;
    @(posedge clk);
    #1;
    cs_n = 1'b1;
    data = reg_dout;
  endtask

  task automatic wait_until(input int unsigned pos);
    while (edge_cnt < pos) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic check_frame_done();
    check_equal(32'(exp_addr.size()), 0, "memory accesses missing at frame end");
    check_equal(32'(exp_pix.size()), 0, "pixel pairs missing at frame end");
  endtask

  // Reference model of one frame built from the bad-line and fetch rules
  task automatic build_frame(input int unsigned frame, input logic [7:0] ctrl_val,
                             input logic [7:0] memptr_val, input logic [7:0] bg_val);
    logic [7:0]  codes [`VIC_COLS];
    logic [3:0]  colors [`VIC_COLS];
    logic [13:0] addr;
    logic [7:0]  pattern;
    logic [2:0]  rc;
    logic [9:0]  vcb;
    logic        shown;
    logic        bad;
    logic        in_win;
    int unsigned base;
    shown = 1'b0;
    vcb = '0;
    rc = '0;
    base = frame * FRAME_CYCLES;
    for (int line = 0; line < `VIC_LINES; line++) begin
      in_win = (line >= `VIC_DISP_FIRST) && (line <= `VIC_DISP_LAST);
      bad = in_win && ctrl_val[4] && (3'(line) == ctrl_val[2:0]);
      // A bad line fetches the text row and restarts the glyph row
      if (bad) begin
        shown = 1'b1;
        rc = '0;
        for (int k = 0; k < `VIC_COLS; k++) begin
          addr = {memptr_val[7:4], vcb + 10'(k)};
          exp_addr.push_back(addr);
          exp_pos.push_back(base + line * `VIC_LINE_CYCLES + `VIC_C_START +
                            k * `VIC_ACC_CYCLES);
          exp_is_c.push_back(1'b1);
          codes[k] = vram_ref[addr][7:0];
          colors[k] = vram_ref[addr][11:8];
        end
        vcb = vcb + 10'(`VIC_COLS);
      end else if (in_win && shown) begin
        rc = rc + 3'd1;
      end
      // Glyph fetches and pixel pairs of a display line with the MSB first
      if (in_win && shown) begin
        for (int k = 0; k < `VIC_COLS; k++) begin
          addr = {memptr_val[3:1], codes[k], rc};
          exp_addr.push_back(addr);
          exp_pos.push_back(base + line * `VIC_LINE_CYCLES + `VIC_G_START +
                            k * `VIC_ACC_CYCLES);
          exp_is_c.push_back(1'b0);
          pattern = vram_ref[addr][7:0];
          for (int j = 0; j < 4; j++) begin
            exp_pix.push_back({pattern[7 - 2 * j] ? colors[k] : bg_val[3:0],
                               pattern[6 - 2 * j] ? colors[k] : bg_val[3:0]});
          end
        end
      end
    end
  endtask

  // ==========================================================================
  // Bus and pixel monitor sampled mid-clock
  // ==========================================================================

  always @(negedge clk) begin
    if (rst) begin
      ras_prev = 1'b1;
      cas_prev = 1'b1;
      ba_low_run = 0;
    end else begin
      // Frame 0 runs with den clear, so the core must stay quiet
      if (edge_cnt < FRAME_CYCLES) begin
        if (!ras_n) begin
          $display("ras_n went low at %0t while den was clear", $time);
          stop_run();
        end
        check_equal(32'(ba), 1, "ba while den is clear");
        check_equal(32'(pix_valid), 0, "pix_valid while den is clear");
      end
      if (!ras_n && ras_prev) begin
        if (exp_addr.size() == 0) begin
          $display("Memory access at %0t that the fetch rules do not call for", $time);
          stop_run();
        end
        cur_addr = exp_addr.pop_front();
        cur_pos = exp_pos.pop_front();
        cur_is_c = exp_is_c.pop_front();
        check_equal(edge_cnt, cur_pos, "frame position of access start");
        check_equal(32'(mem_adr), 32'(cur_addr[7:0]), "row address");
        if (cur_is_c && (ba_low_run < 4)) begin
          $display("ba fell only %0d clocks before a c-access at %0t", ba_low_run, $time);
          stop_run();
        end
        // The c-accesses are over before the first glyph fetch and ba is high again
        if (!cur_is_c) begin
          check_equal(32'(ba), 1, "ba during a g-access");
        end
      end
      if (!cas_n && cas_prev) begin
        check_equal(edge_cnt, cur_pos + 1, "column strobe one clock after the row strobe");
        check_equal(32'(mem_adr), {26'd0, cur_addr[13:8]}, "column address");
      end
      if (pix_valid) begin
        if (exp_pix.size() == 0) begin
          $display("Pixel pair at %0t beyond the expected stream", $time);
          stop_run();
        end
        check_equal(32'(pix_color), 32'(exp_pix.pop_front()), "pixel pair colour");
      end
      ras_prev = ras_n;
      cas_prev = cas_n;
      ba_low_run = ba ? 0 : ba_low_run + 1;
    end
  end

  // ==========================================================================
  // Test sequence
  // ==========================================================================

  initial begin
    logic [31:0] entry;
    logic [7:0]  rd_val;
    int unsigned rd_pos;
    cs_n = 1'b1;
    rw = 1'b1;
    reg_adr = '0;
    reg_din = '0;
    rst = 1'b1;
    fill_video_ram();
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;

    // Register map and raster readback all happen inside frame 0
    for (int i = 0; i < TABLE_LEN; i++) begin
      entry = REG_TABLE[i];
      case (entry[31:24])
        OP_WR: bus_write(entry[21:16], entry[15:8]);
        OP_RD: begin
          bus_read(entry[21:16], rd_val, rd_pos);
          check_equal(32'(rd_val), 32'(entry[7:0]), $sformatf("table entry %0d read", i));
        end
        OP_RAS: begin
          bus_read(REG_RASTER, rd_val, rd_pos);
          check_equal(32'(rd_val), (rd_pos / `VIC_LINE_CYCLES) % `VIC_LINES,
                      $sformatf("table entry %0d raster", i));
        end
        default: repeat (entry[15:8]) @(posedge clk);
      endcase
    end

    // Line 23 has no fetches, so the next frame sees a stable setup
    wait_until(FRAME_CYCLES - 40);
    check_frame_done();
    bus_write(REG_MEMPTR, 8'h5a);
    bus_write(REG_BGCOLOR, 8'h03);
    bus_write(REG_CTRL, 8'h13);
    bus_read(REG_CTRL, rd_val, rd_pos);
    check_equal(32'(rd_val), 32'h13, "ctrl read with den set");
    build_frame(1, 8'h13, 8'h5a, 8'h03);

    // Moving yscroll shifts the bad lines from 11 and 19 to 6 and 14
    wait_until(2 * FRAME_CYCLES - 40);
    check_frame_done();
    bus_write(REG_CTRL, 8'h16);
    bus_read(REG_CTRL, rd_val, rd_pos);
    check_equal(32'(rd_val), 32'h16, "ctrl read after yscroll change");
    build_frame(2, 8'h16, 8'h5a, 8'h03);

    wait_until(3 * FRAME_CYCLES);
    check_frame_done();
    $display("=== PASS ===");
    $finish;
  end

endmodule

/* tb/vic_mem_model.sv */
// Video and colour RAM model

module vic_mem_model (
  input  logic        clk,
  input  logic        rst,
  input  logic [7:0]  mem_adr,
  input  logic        ras_n,
  input  logic        cas_n,
  output logic [11:0] mem_dat
);

  // 16K words of 14-bit address, colour nibble in data bits 11:8
  logic [11:0] ram [16384];
  logic [7:0]  row_q;
  logic [5:0]  col_q;
  logic        ras_q;
  logic        cas_q;

  // A strobe is seen low at the end of the clock where it falls,
  // together with the address half that it qualifies
  always_ff @(posedge clk) begin
    if (rst) begin
      row_q <= '0;
      col_q <= '0;
      ras_q <= 1'b1;
      cas_q <= 1'b1;
    end else begin
      ras_q <= ras_n;
      cas_q <= cas_n;
      if (!ras_n && ras_q) begin
        row_q <= mem_adr;
      end
      if (!cas_n && cas_q) begin
        col_q <= mem_adr[5:0];
      end
    end
  end

  // Data is ready for the whole data phase that follows the column strobe
  assign mem_dat = rst ? 12'h000 : ram[{col_q, row_q}];

endmodule

/* vic_fetch.f */
+incdir+source
source/vic_reg_pkg.sv
source/vic_fetch_pkg.sv
source/vic_if.sv
source/vic_reg_decode.sv
source/vic_fetch_seq.sv
source/vic_pixel_out.sv
source/vic_fetch_top.sv
tb/vic_mem_model.sv
tb/vic_fetch_tb.sv
